//--- verilog/mem_pkg.sv
package mem_pkg;

    // ------------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------------

    localparam int XLEN        = 32;             // Data path width
    localparam int BYTE_LANES  = XLEN / 8;       // Bytes per data word
    localparam int DMEM_WORDS  = 256;            // Data memory depth in words
    localparam int DMEM_ADDR_W = 10;             // Byte address bits into data memory

    // ------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------

    typedef logic [XLEN-1:0]          data_t;       // ALU result, store/load data
    typedef logic [XLEN-1:0]          inst_addr_t;  // Program counter
    typedef logic [DMEM_ADDR_W-1:0]   data_addr_t;  // Byte address, local memory
    typedef logic [DMEM_ADDR_W-3:0]   word_addr_t;  // Word index, drops byte offset
    typedef logic [BYTE_LANES-1:0]    byte_en_t;    // One bit per byte lane

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------

    // Access size, as decoded from funct3
    typedef enum logic [1:0] {
        ACC_BYTE = 2'd0,
        ACC_HALF = 2'd1,
        ACC_WORD = 2'd2
    } access_e;

    // Register write-back source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,                           // ALU result
        WB_MEM = 2'd1,                           // Formatted load data
        WB_PC4 = 2'd2                            // Link address for JAL/JALR
    } wb_sel_e;

    // Load wait FSM
    typedef enum logic {
        ST_IDLE      = 1'b0,
        ST_LOAD_WAIT = 1'b1
    } adapter_state_e;

endpackage

//--- verilog/mem_stage_latch.sv
`timescale 1ns/1ns

module mem_stage_latch (
    input  logic                 i_clock,
    input  logic                 i_arst_n,
    input  logic                 i_stall,           // Hold contents while high

    // From execute stage
    input  logic                 i_is_valid,
    input  mem_pkg::inst_addr_t  i_pc,
    input  mem_pkg::data_t       i_data_r,          // ALU result / address
    input  mem_pkg::data_t       i_data_b,          // Store data
    input  logic                 i_mem_wr_enable,
    input  logic                 i_mem_rd_enable,
    input  mem_pkg::access_e     i_mem_access,
    input  logic                 i_mem_unsigned,
    input  mem_pkg::wb_sel_e     i_reg_wr_data_sel,

    // Latched operation
    output logic                 o_is_valid,
    output mem_pkg::inst_addr_t  o_pc,
    output mem_pkg::data_t       o_data_r,
    output mem_pkg::data_t       o_data_b,
    output logic                 o_mem_wr_enable,
    output logic                 o_mem_rd_enable,
    output mem_pkg::access_e     o_mem_access,
    output logic                 o_mem_unsigned,
    output mem_pkg::wb_sel_e     o_reg_wr_data_sel
);

    // Only the valid bit is control state
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_is_valid <= 1'b0;
        end else if (!i_stall) begin
            o_is_valid <= i_is_valid;
        end
    end

    // Payload follows valid, no reset
    always_ff @(posedge i_clock) begin
        if (!i_stall) begin
            o_pc              <= i_pc;
            o_data_r          <= i_data_r;
            o_data_b          <= i_data_b;
            o_mem_wr_enable   <= i_mem_wr_enable;
            o_mem_rd_enable   <= i_mem_rd_enable;
            o_mem_access      <= i_mem_access;
            o_mem_unsigned    <= i_mem_unsigned;
            o_reg_wr_data_sel <= i_reg_wr_data_sel;
        end
    end

    // A decoded instruction is either a load or a store, never both
    a_no_rd_wr : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_is_valid |-> !(o_mem_wr_enable && o_mem_rd_enable));

endmodule

//--- verilog/mem_access_adapter.sv
`timescale 1ns/1ns

module mem_access_adapter (
    input  logic                  i_clock,
    input  logic                  i_arst_n,

    // Latched operation
    input  logic                  i_is_valid,
    input  mem_pkg::data_addr_t   i_addr,          // Byte address
    input  mem_pkg::data_t        i_wr_data,       // Store data, low aligned
    input  logic                  i_wr_enable,
    input  logic                  i_rd_enable,
    input  mem_pkg::access_e      i_access,
    input  logic                  i_unsigned,

    // Data memory side
    output mem_pkg::word_addr_t   o_mem_addr,
    output mem_pkg::byte_en_t     o_mem_byte_en,
    output mem_pkg::data_t        o_mem_wr_data,
    output logic                  o_mem_rd,
    input  mem_pkg::data_t        i_mem_rd_data,   // Valid one cycle after o_mem_rd

    // Toward write-back
    output mem_pkg::data_t        o_rd_data,       // Shifted and extended load data
    output logic                  o_result_valid,
    output logic                  o_align_error,
    output logic                  o_stall          // Also exported as hazard
);

    mem_pkg::adapter_state_e state;
    mem_pkg::adapter_state_e state_next;

    mem_pkg::byte_en_t       lane_en;              // Lanes touched by this size/offset
    mem_pkg::data_t          lane_data;            // Store data copied to all lanes
    logic                    misaligned;
    logic                    in_idle;
    logic                    load_go;              // Aligned load starts this cycle

    logic [1:0]              ld_offset;            // Byte offset of pending load
    mem_pkg::access_e        ld_access;
    logic                    ld_unsigned;
    mem_pkg::data_t          ld_shifted;

    // ------------------------------------------------------------------
    // Lane decode for stores and alignment check
    // ------------------------------------------------------------------

    always_comb begin
        case (i_access)
            mem_pkg::ACC_BYTE: begin
                lane_en    = 4'b0001 << i_addr[1:0];
                lane_data  = {4{i_wr_data[7:0]}};       // Byte in every lane
                misaligned = 1'b0;
            end
            mem_pkg::ACC_HALF: begin
                lane_en    = 4'b0011 << {i_addr[1], 1'b0};
                lane_data  = {2{i_wr_data[15:0]}};      // Half in both halves
                misaligned = i_addr[0];
            end
            default: begin                              // Word
                lane_en    = 4'b1111;
                lane_data  = i_wr_data;
                misaligned = |i_addr[1:0];
            end
        endcase
    end

    assign in_idle = (state == mem_pkg::ST_IDLE);
    assign load_go = in_idle && i_is_valid && i_rd_enable && !misaligned;

    assign o_mem_addr    = i_addr[mem_pkg::DMEM_ADDR_W-1:2];
    assign o_mem_wr_data = lane_data;
    assign o_mem_byte_en = (in_idle && i_is_valid && i_wr_enable && !misaligned) ?
                           lane_en : '0;            // Misaligned store writes nothing
    assign o_mem_rd      = load_go;
    assign o_stall       = load_go;                 // One stall cycle per load

    // Error only in idle; a waiting load was checked when issued
    assign o_align_error = in_idle && i_is_valid && (i_wr_enable || i_rd_enable) &&
                           misaligned;

    // A load reports in its wait cycle while the latch still holds it
    assign o_result_valid = in_idle ? (i_is_valid && !load_go) : i_is_valid;

    // ------------------------------------------------------------------
    // Load wait FSM
    // ------------------------------------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::ST_IDLE:      if (load_go) state_next = mem_pkg::ST_LOAD_WAIT;
            mem_pkg::ST_LOAD_WAIT: state_next = mem_pkg::ST_IDLE;
            default:               state_next = mem_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) state <= mem_pkg::ST_IDLE;
        else           state <= state_next;
    end

    // Format of the pending load, kept for the data return cycle
    always_ff @(posedge i_clock) begin
        if (load_go) begin
            ld_offset   <= i_addr[1:0];
            ld_access   <= i_access;
            ld_unsigned <= i_unsigned;
        end
    end

    // Move addressed lane down to bit 0, then extend
    assign ld_shifted = i_mem_rd_data >> {ld_offset, 3'b000};

    always_comb begin
        case (ld_access)
            mem_pkg::ACC_BYTE:
                o_rd_data = {{(mem_pkg::XLEN-8){~ld_unsigned & ld_shifted[7]}},
                             ld_shifted[7:0]};
            mem_pkg::ACC_HALF:
                o_rd_data = {{(mem_pkg::XLEN-16){~ld_unsigned & ld_shifted[15]}},
                             ld_shifted[15:0]};
            default:
                o_rd_data = ld_shifted;
        endcase
    end

    // Hazard is a single-cycle pulse, never back-to-back
    a_stall_pulse : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_stall |=> !o_stall);

    a_no_en_on_error : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_align_error |-> (o_mem_byte_en == '0));

    a_wait_has_result : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (state == mem_pkg::ST_LOAD_WAIT) |-> o_result_valid);

endmodule

//--- verilog/data_memory.sv
`timescale 1ns/1ns

module data_memory (
    input  logic                 i_clock,
    input  mem_pkg::word_addr_t  i_addr,       // Word index
    input  mem_pkg::byte_en_t    i_byte_en,    // Nonzero means write
    input  mem_pkg::data_t       i_wr_data,    // Already placed in lanes
    input  logic                 i_rd,         // Read strobe
    output mem_pkg::data_t       o_rd_data     // Registered read data
);

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------

    mem_pkg::data_t mem [mem_pkg::DMEM_WORDS];

    // Per-lane write, unselected lanes keep their bytes
    always_ff @(posedge i_clock) begin
        for (int lane = 0; lane < mem_pkg::BYTE_LANES; lane++) begin
            if (i_byte_en[lane]) begin
                mem[i_addr][lane*8 +: 8] <= i_wr_data[lane*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------

    // One cycle latency; output holds between reads
    always_ff @(posedge i_clock) begin
        if (i_rd) begin
            o_rd_data <= mem[i_addr];
        end
    end

    // Adapter serializes accesses, single port is never shared
    a_no_rd_wr : assert property (@(posedge i_clock)
        !(i_rd && (i_byte_en != '0)));

endmodule

//--- verilog/writeback_select.sv
`timescale 1ns/1ns

module writeback_select (
    input  logic                 i_clock,
    input  logic                 i_arst_n,

    input  logic                 i_result_valid,  // Operation completes this cycle
    input  logic                 i_align_error,
    input  mem_pkg::inst_addr_t  i_pc,
    input  mem_pkg::data_t       i_data_r,        // ALU result
    input  mem_pkg::data_t       i_rd_data,       // Load data
    input  mem_pkg::wb_sel_e     i_sel,

    output logic                 o_wb_valid,
    output mem_pkg::data_t       o_wb_data,
    output logic                 o_align_error
);

    mem_pkg::inst_addr_t pc_plus4;
    mem_pkg::data_t      wb_mux;

    assign pc_plus4 = i_pc + mem_pkg::inst_addr_t'(4);  // Link address

    // ------------------------------------------------------------------
    // Source select, zero on alignment error
    // ------------------------------------------------------------------

    always_comb begin
        case (i_sel)
            mem_pkg::WB_ALU: wb_mux = i_data_r;
            mem_pkg::WB_MEM: wb_mux = i_rd_data;
            mem_pkg::WB_PC4: wb_mux = pc_plus4;
            default:         wb_mux = '0;
        endcase
        if (i_align_error) wb_mux = '0;
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_valid    <= 1'b0;
            o_align_error <= 1'b0;
        end else begin
            o_wb_valid    <= i_result_valid;
            o_align_error <= i_result_valid & i_align_error;
        end
    end

    // Data word, no reset
    always_ff @(posedge i_clock) begin
        o_wb_data <= wb_mux;
    end

    a_sel_legal : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_result_valid |-> (i_sel inside {mem_pkg::WB_ALU, mem_pkg::WB_MEM,
                                          mem_pkg::WB_PC4}));

endmodule

//--- verilog/stage_mem.sv
`timescale 1ns/1ns

module stage_mem (
    input  logic                 i_clock,
    input  logic                 i_arst_n,

    // From execute stage
    input  logic                 i_is_valid,
    input  mem_pkg::inst_addr_t  i_pc,
    input  mem_pkg::data_t       i_data_r,           // ALU result, also the address
    input  mem_pkg::data_t       i_data_b,           // Store data
    input  logic                 i_mem_wr_enable,
    input  logic                 i_mem_rd_enable,
    input  mem_pkg::access_e     i_mem_access,
    input  logic                 i_mem_unsigned,
    input  mem_pkg::wb_sel_e     i_reg_wr_data_sel,

    output logic                 o_hazard,           // Upstream holds while high
    output logic                 o_wb_valid,
    output mem_pkg::data_t       o_wb_data,
    output logic                 o_align_error
);

    // Latched operation
    logic                 op_valid;
    mem_pkg::inst_addr_t  op_pc;
    mem_pkg::data_t       op_data_r;
    mem_pkg::data_t       op_data_b;
    logic                 op_wr_enable;
    logic                 op_rd_enable;
    mem_pkg::access_e     op_access;
    logic                 op_unsigned;
    mem_pkg::wb_sel_e     op_wb_sel;

    // Adapter to memory
    mem_pkg::word_addr_t  dmem_addr;
    mem_pkg::byte_en_t    dmem_byte_en;
    mem_pkg::data_t       dmem_wr_data;
    logic                 dmem_rd;
    mem_pkg::data_t       dmem_rd_data;

    // Adapter to write-back
    mem_pkg::data_t       load_data;
    logic                 result_valid;
    logic                 align_error;
    logic                 stall;

    assign o_hazard = stall;

    mem_stage_latch u_latch (
        .i_clock (i_clock), .i_arst_n (i_arst_n), .i_stall (stall),
        .i_is_valid (i_is_valid), .i_pc (i_pc), .i_data_r (i_data_r),
        .i_data_b (i_data_b), .i_mem_wr_enable (i_mem_wr_enable),
        .i_mem_rd_enable (i_mem_rd_enable), .i_mem_access (i_mem_access),
        .i_mem_unsigned (i_mem_unsigned), .i_reg_wr_data_sel (i_reg_wr_data_sel),
        .o_is_valid (op_valid), .o_pc (op_pc), .o_data_r (op_data_r),
        .o_data_b (op_data_b), .o_mem_wr_enable (op_wr_enable),
        .o_mem_rd_enable (op_rd_enable), .o_mem_access (op_access),
        .o_mem_unsigned (op_unsigned), .o_reg_wr_data_sel (op_wb_sel));

    // Address wraps on the low bits of the ALU result
    mem_access_adapter u_adapter (
        .i_clock (i_clock), .i_arst_n (i_arst_n), .i_is_valid (op_valid),
        .i_addr (op_data_r[mem_pkg::DMEM_ADDR_W-1:0]), .i_wr_data (op_data_b),
        .i_wr_enable (op_wr_enable), .i_rd_enable (op_rd_enable),
        .i_access (op_access), .i_unsigned (op_unsigned),
        .o_mem_addr (dmem_addr), .o_mem_byte_en (dmem_byte_en),
        .o_mem_wr_data (dmem_wr_data), .o_mem_rd (dmem_rd),
        .i_mem_rd_data (dmem_rd_data), .o_rd_data (load_data),
        .o_result_valid (result_valid), .o_align_error (align_error),
        .o_stall (stall));

    data_memory u_dmem (
        .i_clock (i_clock), .i_addr (dmem_addr), .i_byte_en (dmem_byte_en),
        .i_wr_data (dmem_wr_data), .i_rd (dmem_rd), .o_rd_data (dmem_rd_data));

    writeback_select u_wb (
        .i_clock (i_clock), .i_arst_n (i_arst_n), .i_result_valid (result_valid),
        .i_align_error (align_error), .i_pc (op_pc), .i_data_r (op_data_r),
        .i_rd_data (load_data), .i_sel (op_wb_sel),
        .o_wb_valid (o_wb_valid), .o_wb_data (o_wb_data),
        .o_align_error (o_align_error));

endmodule

//--- sim/tb_stage_mem.sv
`timescale 1ns/1ns

module tb_stage_mem;

    logic                 i_clock = 1'b0;
    logic                 i_arst_n;
    logic                 i_is_valid;
    mem_pkg::inst_addr_t  i_pc;
    mem_pkg::data_t       i_data_r;
    mem_pkg::data_t       i_data_b;
    logic                 i_mem_wr_enable;
    logic                 i_mem_rd_enable;
    mem_pkg::access_e     i_mem_access;
    logic                 i_mem_unsigned;
    mem_pkg::wb_sel_e     i_reg_wr_data_sel;
    logic                 o_hazard;
    logic                 o_wb_valid;
    mem_pkg::data_t       o_wb_data;
    logic                 o_align_error;

    logic [7:0]      ref_mem [2**mem_pkg::DMEM_ADDR_W];  // Byte image of data memory
    logic [31:0]     seed = 32'h01df256d;
    int              cycle = 0;                          // Rising edges so far
    int              hazard_count = 0;                   // Cycles with o_hazard high
    int              errors = 0;
    int              checks = 0;
    int              wait_limit = 64;                    // Cycles per wait loop

    // Expected and observed results in issue order
    mem_pkg::data_t  exp_data_q[$];
    logic            exp_err_q[$];
    int              exp_cyc_q[$];
    mem_pkg::data_t  obs_data_q[$];
    logic            obs_err_q[$];
    int              obs_cyc_q[$];

    stage_mem i_dut (.*);

    always #4 i_clock = ~i_clock;                        // 8 ns period

    always @(posedge i_clock) cycle <= cycle + 1;

    // Output monitor, samples in the middle of the cycle
    always @(negedge i_clock) begin
        if (i_arst_n && o_hazard) hazard_count++;
        if (i_arst_n && o_wb_valid) begin
            obs_data_q.push_back(o_wb_data);
            obs_err_q.push_back(o_align_error);
            obs_cyc_q.push_back(cycle);
        end
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    function logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic is_misaligned(input logic [9:0] a, input mem_pkg::access_e acc);
        return (acc == mem_pkg::ACC_HALF && a[0]) ||
               (acc == mem_pkg::ACC_WORD && a[1:0] != 2'b00);
    endfunction

    // Little-endian gather from the byte image, then extend
    function automatic mem_pkg::data_t ref_load(input logic [9:0] a,
                                                input mem_pkg::access_e acc, input logic uns);
        case (acc)
            mem_pkg::ACC_BYTE: return {{24{!uns && ref_mem[a][7]}}, ref_mem[a]};
            mem_pkg::ACC_HALF: return {{16{!uns && ref_mem[a + 10'd1][7]}},
                                       ref_mem[a + 10'd1], ref_mem[a]};
            default:           return {ref_mem[a + 10'd3], ref_mem[a + 10'd2],
                                       ref_mem[a + 10'd1], ref_mem[a]};
        endcase
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout: no %s within %0d cycles", what, wait_limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display(">>> FAIL");
        $finish;
    endtask

    // ------------------------------------------------------------------
    // Drive and collect
    // ------------------------------------------------------------------

    // Predict the result, present the operation, hold it while hazard is up
    task automatic send_op(input logic wr, input logic rd, input mem_pkg::access_e acc,
                           input logic uns, input mem_pkg::wb_sel_e sel,
                           input mem_pkg::data_t data_r, input mem_pkg::data_t data_b);
        logic [9:0]          a;
        logic [9:0]          idx;
        logic                err;
        int                  nbytes;
        int                  b;
        int                  waited;
        mem_pkg::inst_addr_t pc;
        mem_pkg::data_t      exp_d;
        a      = data_r[9:0];                            // Wraps on the low address bits
        pc     = lcg_next() & 32'hffff_fffc;
        err    = (wr || rd) && is_misaligned(a, acc);
        nbytes = (acc == mem_pkg::ACC_BYTE) ? 1 : (acc == mem_pkg::ACC_HALF) ? 2 : 4;
        exp_d  = '0;                                     // Error result is zero
        if (!err) begin
            if (wr) begin
                for (b = 0; b < nbytes; b++) begin
                    idx          = a + 10'(b);
                    ref_mem[idx] = data_b[8*b +: 8];
                end
            end
            case (sel)
                mem_pkg::WB_MEM: exp_d = ref_load(a, acc, uns);
                mem_pkg::WB_PC4: exp_d = pc + 32'd4;
                default:         exp_d = data_r;
            endcase
        end
        exp_data_q.push_back(exp_d);
        exp_err_q.push_back(err);
        @(posedge i_clock);
        i_is_valid        <= 1'b1;
        i_pc              <= pc;
        i_data_r          <= data_r;
        i_data_b          <= data_b;
        i_mem_wr_enable   <= wr;
        i_mem_rd_enable   <= rd;
        i_mem_access      <= acc;
        i_mem_unsigned    <= uns;
        i_reg_wr_data_sel <= sel;
        @(negedge i_clock);
        exp_cyc_q.push_back(cycle);
        waited = 0;
        while (o_hazard) begin                           // Next edge would not sample
            @(negedge i_clock);
            waited++;
            if (waited > wait_limit) abort_run("drop of o_hazard");
        end
    endtask

    task automatic go_idle();
        @(posedge i_clock);
        i_is_valid <= 1'b0;
    endtask

    // Pop the oldest result and compare it
    // Latency counts edges from the drive edge
    task automatic collect(output int latency);
        int             waited;
        mem_pkg::data_t got_d;
        mem_pkg::data_t exp_d;
        logic           got_e;
        logic           exp_e;
        waited = 0;
        while (obs_data_q.size() == 0) begin
            @(negedge i_clock);
            waited++;
            if (waited > wait_limit) abort_run("o_wb_valid");
        end
        got_d   = obs_data_q.pop_front();
        got_e   = obs_err_q.pop_front();
        exp_d   = exp_data_q.pop_front();
        exp_e   = exp_err_q.pop_front();
        latency = obs_cyc_q.pop_front() - exp_cyc_q.pop_front();
        checks++;
        assert (got_d === exp_d && got_e === exp_e) else begin
            $display("Error @%0t: result %h err %b, expected %h err %b",
                     $time, got_d, got_e, exp_d, exp_e);
            errors++;
        end
    endtask

    task automatic drain();
        int lat;
        go_idle();
        while (exp_data_q.size() > 0) collect(lat);
    endtask

    // One isolated operation with latency and hazard checks
    task automatic run_single(input logic wr, input logic rd, input mem_pkg::access_e acc,
                              input logic uns, input mem_pkg::wb_sel_e sel,
                              input mem_pkg::data_t data_r, input mem_pkg::data_t data_b);
        int   h0;
        int   lat;
        logic ld;
        h0 = hazard_count;
        ld = rd && !is_misaligned(data_r[9:0], acc);     // Only aligned loads stall
        send_op(wr, rd, acc, uns, sel, data_r, data_b);
        go_idle();
        collect(lat);
        checks++;
        assert (lat == (ld ? 3 : 2) && hazard_count - h0 == (ld ? 1 : 0)) else begin
            $display("Error @%0t: addr %h latency %0d hazard cycles %0d",
                     $time, data_r, lat, hazard_count - h0);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------

    task automatic fill_memory();
        int i;
        for (i = 0; i < mem_pkg::DMEM_WORDS; i++)    // Back-to-back stores
            send_op(1'b1, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_ALU, i * 4, lcg_next());
        drain();
    endtask

    task automatic alu_and_link_ops();
        int i;
        for (i = 0; i < 4; i++) begin
            run_single(1'b0, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_ALU, lcg_next(), '0);
            run_single(1'b0, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_PC4, lcg_next(), '0);
        end
    endtask

    task automatic word_store_load();
        mem_pkg::data_t addrs [8];
        int             i;
        for (i = 0; i < 8; i++) begin
            addrs[i] = lcg_next() & 32'hffff_fffc;
            run_single(1'b1, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_ALU,
                       addrs[i], lcg_next());
        end
        for (i = 0; i < 8; i++)
            run_single(1'b0, 1'b1, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_MEM, addrs[i], '0);
    endtask

    // Sub-word stores that are each read back as a full word
    task automatic sub_word_stores();
        mem_pkg::data_t base;
        int             off;
        base = lcg_next() & 32'hffff_fffc;
        for (off = 0; off < 4; off++) begin
            run_single(1'b1, 1'b0, mem_pkg::ACC_BYTE, 1'b0, mem_pkg::WB_ALU,
                       base + off, lcg_next());
            run_single(1'b0, 1'b1, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_MEM, base, '0);
        end
        for (off = 0; off < 4; off += 2) begin
            run_single(1'b1, 1'b0, mem_pkg::ACC_HALF, 1'b0, mem_pkg::WB_ALU,
                       base + off, lcg_next());
            run_single(1'b0, 1'b1, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_MEM, base, '0);
        end
    endtask

    task automatic load_extension();
        mem_pkg::data_t base;
        int             off;
        int             uns;
        base = lcg_next() & 32'hffff_fffc;
        // Every byte and half has its top bit set
        run_single(1'b1, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_ALU, base, 32'hf08c_a5e7);
        for (uns = 0; uns < 2; uns++) begin
            for (off = 0; off < 4; off++)
                run_single(1'b0, 1'b1, mem_pkg::ACC_BYTE, 1'(uns), mem_pkg::WB_MEM,
                           base + off, '0);
            for (off = 0; off < 4; off += 2)
                run_single(1'b0, 1'b1, mem_pkg::ACC_HALF, 1'(uns), mem_pkg::WB_MEM,
                           base + off, '0);
        end
    endtask

    task automatic misaligned_access();
        mem_pkg::data_t base;
        int             off;
        base = lcg_next() & 32'hffff_fffc;
        for (off = 1; off < 4; off++) begin
            if (off[0]) begin                            // Odd halfword offsets
                run_single(1'b1, 1'b0, mem_pkg::ACC_HALF, 1'b0, mem_pkg::WB_ALU,
                           base + off, lcg_next());
                run_single(1'b0, 1'b1, mem_pkg::ACC_HALF, 1'b0, mem_pkg::WB_MEM,
                           base + off, '0);
            end
            run_single(1'b1, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_ALU,
                       base + off, lcg_next());
            run_single(1'b0, 1'b1, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_MEM,
                       base + off, '0);
        end
        run_single(1'b0, 1'b1, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_MEM, base, '0);  // Unchanged
    endtask

    // Mixed stream with no idle cycles whose results must come back in order
    task automatic mixed_stream();
        logic [31:0] r;
        int          i;
        int          kind;
        for (i = 0; i < 24; i++) begin
            r    = lcg_next();
            kind = int'((r >> 16) % 5);
            case (kind)
                0: send_op(1'b0, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_ALU, r, '0);
                1: send_op(1'b0, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_PC4, r, '0);
                2: send_op(1'b1, 1'b0, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_ALU,
                           r & 32'hffff_fffc, lcg_next());
                3: send_op(1'b0, 1'b1, mem_pkg::ACC_WORD, 1'b0, mem_pkg::WB_MEM,
                           r & 32'hffff_fffc, '0);
                default: send_op(1'b0, 1'b1, mem_pkg::ACC_BYTE, 1'b0, mem_pkg::WB_MEM, r, '0);
            endcase
        end
        drain();
    endtask

    initial begin
        i_arst_n          <= 1'b0;
        i_is_valid        <= 1'b0;
        i_pc              <= '0;
        i_data_r          <= '0;
        i_data_b          <= '0;
        i_mem_wr_enable   <= 1'b0;
        i_mem_rd_enable   <= 1'b0;
        i_mem_access      <= mem_pkg::ACC_WORD;
        i_mem_unsigned    <= 1'b0;
        i_reg_wr_data_sel <= mem_pkg::WB_ALU;
        repeat (2) @(posedge i_clock);
        i_arst_n <= 1'b1;
        @(negedge i_clock);
        checks++;
        assert (!o_hazard && !o_wb_valid && !o_align_error) else begin
            $display("Error @%0t: outputs not idle after reset", $time);
            errors++;
        end
        fill_memory();
        alu_and_link_ops();
        word_store_load();
        sub_word_stores();
        load_extension();
        misaligned_access();
        mixed_stream();
        repeat (4) @(negedge i_clock);                   // Quiet window for stray results
        checks++;
        assert (obs_data_q.size() == 0) else begin
            $display("Error @%0t: %0d results without a matching operation",
                     $time, obs_data_q.size());
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
verilog/mem_pkg.sv
verilog/mem_stage_latch.sv
verilog/mem_access_adapter.sv
verilog/data_memory.sv
verilog/writeback_select.sv
verilog/stage_mem.sv
sim/tb_stage_mem.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --sv --timing --assert
TOP       ?= tb_stage_mem
RTL_TOP   ?= stage_mem
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint build sim clean

all: sim

# Lint the design alone, then together with the testbench
lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides pass or fail
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
